/* Bender.yml */
package:
  name: chrono

sources:
  - src/chrono_pkg.sv
  - src/chrono_config_regs.sv
  - src/chrono_update_ctrl.sv
  - src/chrono_time_regs.sv
  - src/chrono_top.sv
  - target: test
    files:
      - tb/chrono_tb.sv

/* src.f */
src/chrono_pkg.sv
src/chrono_config_regs.sv
src/chrono_update_ctrl.sv
src/chrono_time_regs.sv
src/chrono_top.sv
tb/chrono_tb.sv

/* src/chrono_config_regs.sv */
`timescale 1ns/1ns

module chrono_config_regs #(
    parameter int STROBE_W     = 8,
    parameter int STROBE_RESET = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_we,
    input  logic                cfg_sel,
    input  logic [STROBE_W-1:0] cfg_wdata,
    output logic [STROBE_W-1:0] strobe_width,
    output logic                edit_enable
);

    //////////////////////////////
    // Register select
    //////////////////////////////

    localparam logic SEL_WIDTH  = 1'b0;
    localparam logic SEL_ENABLE = 1'b1;

    logic width_we;
    logic enable_we;

    assign width_we  = cfg_we && (cfg_sel == SEL_WIDTH);
    assign enable_we = cfg_we && (cfg_sel == SEL_ENABLE);

    //////////////////////////////
    // Registers
    //////////////////////////////

    // Strobe width in cycles minus one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strobe_width <= STROBE_W'(STROBE_RESET);
        end else if (width_we) begin
            strobe_width <= cfg_wdata;
        end
    end

    // Edits are allowed out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            edit_enable <= 1'b1;
        end else if (enable_we) begin
            edit_enable <= cfg_wdata[0];
        end
    end

endmodule

/* src/chrono_pkg.sv */
package chrono_pkg;

    //////////////////////////////
    // Field and address widths
    //////////////////////////////

    localparam int FIELD_W = 6;
    localparam int ADDR_W  = 3;

    // Modulus of each time field
    localparam logic [FIELD_W-1:0] SEC_LIMIT  = FIELD_W'(60);
    localparam logic [FIELD_W-1:0] MIN_LIMIT  = FIELD_W'(60);
    localparam logic [FIELD_W-1:0] HOUR_LIMIT = FIELD_W'(24);

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Register map with 5 to 7 left undecoded
    typedef enum logic [ADDR_W-1:0] {
        ADDR_NONE  = 3'd0,
        ADDR_SEC   = 3'd1,
        ADDR_MIN   = 3'd2,
        ADDR_HOUR  = 3'd3,
        ADDR_ALARM = 3'd4
    } chrono_addr_e;

    // Read-modify-write edit operations
    typedef enum logic [1:0] {
        OP_INC,
        OP_DEC,
        OP_CLEAR,
        OP_SET
    } chrono_op_e;

    // Edit controller FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_READ,
        ST_WRITE,
        ST_ACK
    } ctrl_state_e;

endpackage

/* src/chrono_time_regs.sv */
`timescale 1ns/1ns

module chrono_time_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tick,
    input  logic                           rd_strobe,
    input  logic                           wr_strobe,
    input  logic [chrono_pkg::ADDR_W-1:0]  acc_addr,
    input  logic [chrono_pkg::FIELD_W-1:0] wr_data,
    output logic [chrono_pkg::FIELD_W-1:0] rd_data,
    output logic [chrono_pkg::FIELD_W-1:0] sec,
    output logic [chrono_pkg::FIELD_W-1:0] min,
    output logic [chrono_pkg::FIELD_W-1:0] hour,
    output logic                           alarm
);

    import chrono_pkg::*;

    logic [FIELD_W-1:0] alarm_hour;
    logic               wr_q;
    logic               wr_rise;

    // One write per strobe
    assign wr_rise = wr_strobe && !wr_q;

    //////////////////////////////
    // Strobed read port
    //////////////////////////////

    always_comb begin
        rd_data = '0;
        if (rd_strobe) begin
            case (acc_addr)
                ADDR_SEC:   rd_data = sec;
                ADDR_MIN:   rd_data = min;
                ADDR_HOUR:  rd_data = hour;
                ADDR_ALARM: rd_data = alarm_hour;
                default:    rd_data = '0;
            endcase
        end
    end

    //////////////////////////////
    // Time counting and writes
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sec        <= '0;
            min        <= '0;
            hour       <= '0;
            alarm_hour <= '0;
            wr_q       <= 1'b0;
            alarm      <= 1'b0;
        end else begin
            wr_q  <= wr_strobe;
            alarm <= (hour == alarm_hour);

            if (wr_rise) begin
                // A tick in this cycle is lost
                case (acc_addr)
                    ADDR_SEC:   sec        <= wr_data;
                    ADDR_MIN:   min        <= wr_data;
                    ADDR_HOUR:  hour       <= wr_data;
                    ADDR_ALARM: alarm_hour <= wr_data;
                    default:    ;
                endcase
            end else if (tick) begin
                if (sec == SEC_LIMIT - 1'b1) begin
                    sec <= '0;
                    if (min == MIN_LIMIT - 1'b1) begin
                        min  <= '0;
                        hour <= (hour == HOUR_LIMIT - 1'b1) ? '0 : hour + 1'b1;
                    end else begin
                        min <= min + 1'b1;
                    end
                end else begin
                    sec <= sec + 1'b1;
                end
            end
        end
    end

    // Ticks and edits both keep fields in range
    a_field_range: assert property (@(posedge clk) disable iff (reset)
        (sec < SEC_LIMIT) && (min < MIN_LIMIT) &&
        (hour < HOUR_LIMIT) && (alarm_hour < HOUR_LIMIT));

endmodule

/* src/chrono_top.sv */
`timescale 1ns/1ns

module chrono_top #(
    parameter int STROBE_W     = 8,
    parameter int STROBE_RESET = 3
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  logic [chrono_pkg::ADDR_W-1:0]  addr,
    input  chrono_pkg::chrono_op_e         op,
    input  logic [chrono_pkg::FIELD_W-1:0] set_value,
    input  logic                           cfg_we,
    input  logic                           cfg_sel,
    input  logic [STROBE_W-1:0]            cfg_wdata,
    input  logic                           tick,
    output logic                           ack,
    output logic                           error,
    output logic                           busy,
    output logic [chrono_pkg::FIELD_W-1:0] sec,
    output logic [chrono_pkg::FIELD_W-1:0] min,
    output logic [chrono_pkg::FIELD_W-1:0] hour,
    output logic                           alarm
);

    import chrono_pkg::*;

    logic [STROBE_W-1:0] strobe_width;
    logic                edit_enable;
    logic                rd_strobe;
    logic                wr_strobe;
    logic [ADDR_W-1:0]   acc_addr;
    logic [FIELD_W-1:0]  wr_data;
    logic [FIELD_W-1:0]  rd_data;

    chrono_config_regs #(
        .STROBE_W     (STROBE_W),
        .STROBE_RESET (STROBE_RESET)
    ) chrono_config_regs_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_we       (cfg_we),
        .cfg_sel      (cfg_sel),
        .cfg_wdata    (cfg_wdata),
        .strobe_width (strobe_width),
        .edit_enable  (edit_enable)
    );

    chrono_update_ctrl #(
        .STROBE_W     (STROBE_W)
    ) chrono_update_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .addr         (addr),
        .op           (op),
        .set_value    (set_value),
        .strobe_width (strobe_width),
        .edit_enable  (edit_enable),
        .rd_data      (rd_data),
        .ack          (ack),
        .error        (error),
        .busy         (busy),
        .rd_strobe    (rd_strobe),
        .wr_strobe    (wr_strobe),
        .acc_addr     (acc_addr),
        .wr_data      (wr_data)
    );

    chrono_time_regs chrono_time_regs_i (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .rd_strobe    (rd_strobe),
        .wr_strobe    (wr_strobe),
        .acc_addr     (acc_addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .sec          (sec),
        .min          (min),
        .hour         (hour),
        .alarm        (alarm)
    );

endmodule

/* src/chrono_update_ctrl.sv */
`timescale 1ns/1ns

module chrono_update_ctrl #(
    parameter int STROBE_W = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req,
    input  logic [chrono_pkg::ADDR_W-1:0]       addr,
    input  chrono_pkg::chrono_op_e              op,
    input  logic [chrono_pkg::FIELD_W-1:0]      set_value,
    input  logic [STROBE_W-1:0]                 strobe_width,
    input  logic                                edit_enable,
    input  logic [chrono_pkg::FIELD_W-1:0]      rd_data,
    output logic                                ack,
    output logic                                error,
    output logic                                busy,
    output logic                                rd_strobe,
    output logic                                wr_strobe,
    output logic [chrono_pkg::ADDR_W-1:0]       acc_addr,
    output logic [chrono_pkg::FIELD_W-1:0]      wr_data
);

    import chrono_pkg::*;

    ctrl_state_e         state;
    logic [STROBE_W-1:0] cnt;
    logic [STROBE_W-1:0] width_q;
    chrono_op_e          op_q;
    logic [FIELD_W-1:0]  set_q;
    logic                err_flag;
    logic [FIELD_W-1:0]  lim;
    logic                reject;
    logic [FIELD_W-1:0]  new_value;

    //////////////////////////////
    // Field helpers
    //////////////////////////////

    // Zero marks an undecoded address
    function automatic logic [FIELD_W-1:0] field_limit(input logic [ADDR_W-1:0] a);
        case (a)
            ADDR_SEC:   return SEC_LIMIT;
            ADDR_MIN:   return MIN_LIMIT;
            ADDR_HOUR:  return HOUR_LIMIT;
            ADDR_ALARM: return HOUR_LIMIT;
            default:    return '0;
        endcase
    endfunction

    function automatic logic [FIELD_W-1:0] next_value(
        input chrono_op_e         o,
        input logic [FIELD_W-1:0] cur,
        input logic [FIELD_W-1:0] setv,
        input logic [FIELD_W-1:0] l
    );
        case (o)
            OP_INC:   return (cur == l - 1'b1) ? '0 : cur + 1'b1;
            OP_DEC:   return (cur == '0) ? l - 1'b1 : cur - 1'b1;
            OP_CLEAR: return '0;
            default:  return setv;
        endcase
    endfunction

    assign lim       = field_limit(acc_addr);
    assign reject    = !edit_enable || (lim == '0) || ((op_q == OP_SET) && (set_q >= lim));
    assign new_value = next_value(op_q, rd_data, set_q, lim);

    // Drops as soon as the answer is on the port
    assign busy = (state != ST_IDLE) && !ack;

    //////////////////////////////
    // Edit FSM
    //////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            cnt       <= '0;
            width_q   <= '0;
            acc_addr  <= ADDR_NONE;
            err_flag  <= 1'b0;
            ack       <= 1'b0;
            error     <= 1'b0;
            rd_strobe <= 1'b0;
            wr_strobe <= 1'b0;
        end else begin
            // Strobes lag the state by one cycle
            rd_strobe <= (state == ST_READ);
            wr_strobe <= (state == ST_WRITE);

            case (state)
                ST_IDLE: begin
                    if (req) begin
                        acc_addr <= addr;
                        width_q  <= strobe_width;
                        state    <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    cnt <= '0;
                    if (reject) begin
                        err_flag <= 1'b1;
                        state    <= ST_ACK;
                    end else begin
                        err_flag <= 1'b0;
                        state    <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (cnt == width_q) begin
                        cnt   <= '0;
                        state <= ST_WRITE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (cnt == width_q) begin
                        state <= ST_ACK;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!ack) begin
                        // Wait for the write strobe to clear
                        if (!wr_strobe) begin
                            ack   <= 1'b1;
                            error <= err_flag;
                        end
                    end else if (!req) begin
                        ack   <= 1'b0;
                        error <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Request payload
    //////////////////////////////

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && req) begin
            op_q  <= op;
            set_q <= set_value;
        end
        // Last read cycle
        if ((state == ST_WRITE) && rd_strobe) begin
            wr_data <= new_value;
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////

    a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
        !(rd_strobe && wr_strobe));

    a_ack_on_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req));

    a_wr_after_rd: assert property (@(posedge clk) disable iff (reset)
        $rose(wr_strobe) |-> $past(rd_strobe));

endmodule

/* tb/chrono_tb.sv */
`timescale 1ns/1ns

module chrono_tb;

    import chrono_pkg::*;

    localparam int STROBE_W     = 8;
    localparam int STROBE_RESET = 3;
    localparam int MAX_ROWS     = 96;

    // Step kinds
    localparam int K_CFG  = 0;
    localparam int K_TICK = 1;
    localparam int K_EDIT = 2;

    logic                clk;
    logic                reset;
    logic                req;
    logic [ADDR_W-1:0]   addr;
    chrono_op_e          op;
    logic [FIELD_W-1:0]  set_value;
    logic                cfg_we;
    logic                cfg_sel;
    logic [STROBE_W-1:0] cfg_wdata;
    logic                tick;
    logic                ack;
    logic                error;
    logic                busy;
    logic [FIELD_W-1:0]  sec;
    logic [FIELD_W-1:0]  min;
    logic [FIELD_W-1:0]  hour;
    logic                alarm;

    chrono_top #(
        .STROBE_W     (STROBE_W),
        .STROBE_RESET (STROBE_RESET)
    ) chrono_top_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .addr      (addr),
        .op        (op),
        .set_value (set_value),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .tick      (tick),
        .ack       (ack),
        .error     (error),
        .busy      (busy),
        .sec       (sec),
        .min       (min),
        .hour      (hour),
        .alarm     (alarm)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus table and model
    //////////////////////////////

    int kind_tab [MAX_ROWS];
    int arg_a    [MAX_ROWS];
    int arg_b    [MAX_ROWS];
    int arg_c    [MAX_ROWS];
    int exp_err  [MAX_ROWS];
    int exp_lat  [MAX_ROWS];
    int wid_tab  [MAX_ROWS];
    int exp_sec  [MAX_ROWS];
    int exp_min  [MAX_ROWS];
    int exp_hour [MAX_ROWS];
    int exp_alm  [MAX_ROWS];
    int rows;
    int errors;

    int m_sec;
    int m_min;
    int m_hour;
    int m_alarm_hour;
    int m_enable;
    int m_width;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Modulus per register or 0 for undecoded addresses
    function automatic int limit_of(input int a);
        if (a == 1 || a == 2) begin
            return 60;
        end else if (a == 3 || a == 4) begin
            return 24;
        end
        return 0;
    endfunction

    function automatic int model_read(input int a);
        case (a)
            1:       return m_sec;
            2:       return m_min;
            3:       return m_hour;
            default: return m_alarm_hour;
        endcase
    endfunction

    task automatic model_write(input int a, input int v);
        case (a)
            1:       m_sec = v;
            2:       m_min = v;
            3:       m_hour = v;
            default: m_alarm_hour = v;
        endcase
    endtask

    // Snapshot of the model after the step
    task automatic push_row(input int k, input int a, input int b, input int c,
                            input int err, input int lat);
        kind_tab[rows] = k;
        arg_a[rows]    = a;
        arg_b[rows]    = b;
        arg_c[rows]    = c;
        exp_err[rows]  = err;
        exp_lat[rows]  = lat;
        wid_tab[rows]  = m_width;
        exp_sec[rows]  = m_sec;
        exp_min[rows]  = m_min;
        exp_hour[rows] = m_hour;
        exp_alm[rows]  = (m_hour == m_alarm_hour);
        rows++;
    endtask

    task automatic add_cfg(input int sel, input int data);
        if (sel == 0) begin
            m_width = data;
        end else begin
            m_enable = data & 1;
        end
        push_row(K_CFG, sel, data, 0, 0, 0);
    endtask

    task automatic add_ticks(input int n);
        for (int k = 0; k < n; k++) begin
            m_sec = (m_sec + 1) % 60;
            if (m_sec == 0) begin
                m_min = (m_min + 1) % 60;
                if (m_min == 0) begin
                    m_hour = (m_hour + 1) % 24;
                end
            end
        end
        push_row(K_TICK, n, 0, 0, 0, 0);
    endtask

    task automatic add_edit(input int a, input int o, input int v);
        int lim;
        int err;
        int cur;
        lim = limit_of(a);
        err = (m_enable == 0) || (lim == 0) || (o == int'(OP_SET) && v >= lim);
        if (!err) begin
            cur = model_read(a);
            if (o == int'(OP_INC)) begin
                model_write(a, (cur + 1) % lim);
            end else if (o == int'(OP_DEC)) begin
                model_write(a, (cur + lim - 1) % lim);
            end else if (o == int'(OP_CLEAR)) begin
                model_write(a, 0);
            end else begin
                model_write(a, v);
            end
        end
        push_row(K_EDIT, a, o, v, err, err ? 2 : 2 * (m_width + 1) + 3);
    endtask

    task automatic build_table();
        int a;
        // Ticks and edits on every field including the wrap cases
        add_ticks(5);
        add_edit(ADDR_SEC, OP_INC, 0);
        add_edit(ADDR_SEC, OP_SET, 59);
        add_edit(ADDR_SEC, OP_INC, 0);
        add_edit(ADDR_SEC, OP_DEC, 0);
        add_edit(ADDR_MIN, OP_SET, 59);
        add_ticks(2);
        add_edit(ADDR_MIN, OP_CLEAR, 0);
        add_edit(ADDR_MIN, OP_DEC, 0);
        add_edit(ADDR_MIN, OP_INC, 0);
        add_edit(ADDR_HOUR, OP_SET, 23);
        add_edit(ADDR_HOUR, OP_INC, 0);
        add_edit(ADDR_HOUR, OP_DEC, 0);
        add_edit(ADDR_MIN, OP_SET, 59);
        add_edit(ADDR_SEC, OP_SET, 50);
        add_ticks(15);
        add_edit(ADDR_ALARM, OP_DEC, 0);
        add_edit(ADDR_ALARM, OP_CLEAR, 0);
        // Random sets and tick bursts
        for (int k = 0; k < 5; k++) begin
            rng = xorshift32(rng);
            a = 1 + int'(rng % 4);
            rng = xorshift32(rng);
            add_edit(a, OP_SET, int'(rng % limit_of(a)));
            rng = xorshift32(rng);
            add_ticks(1 + int'(rng % 150));
        end
        // Rejected requests
        add_edit(ADDR_NONE, OP_INC, 0);
        add_edit(5, OP_INC, 0);
        add_edit(7, OP_CLEAR, 0);
        add_edit(ADDR_SEC, OP_SET, 60);
        add_edit(ADDR_HOUR, OP_SET, 24);
        add_edit(ADDR_ALARM, OP_SET, 30);
        // Edit enable and strobe width
        add_cfg(1, 0);
        add_edit(ADDR_SEC, OP_INC, 0);
        add_edit(ADDR_HOUR, OP_CLEAR, 0);
        add_edit(ADDR_ALARM, OP_SET, 5);
        add_cfg(1, 1);
        add_cfg(0, 0);
        add_edit(ADDR_SEC, OP_INC, 0);
        add_edit(ADDR_MIN, OP_DEC, 0);
        add_cfg(0, 10);
        add_edit(ADDR_HOUR, OP_INC, 0);
        add_edit(ADDR_SEC, OP_SET, 33);
        // Alarm follows hour against alarm hour
        add_edit(ADDR_ALARM, OP_SET, m_hour);
        add_edit(ADDR_HOUR, OP_INC, 0);
        add_edit(ADDR_ALARM, OP_INC, 0);
        add_edit(ADDR_HOUR, OP_DEC, 0);
    endtask

    //////////////////////////////
    // Drivers and checks
    //////////////////////////////

    task automatic check_value(input string name, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic run_config(input int i);
        cfg_sel   = arg_a[i][0];
        cfg_wdata = arg_b[i][STROBE_W-1:0];
        cfg_we    = 1'b1;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic run_ticks(input int i);
        tick = 1'b1;
        repeat (arg_a[i]) @(negedge clk);
        tick = 1'b0;
    endtask

    task automatic run_edit(input int i);
        int cycles;
        int limit;
        int hold;
        addr      = arg_a[i][ADDR_W-1:0];
        op        = chrono_op_e'(arg_b[i][1:0]);
        set_value = arg_c[i][FIELD_W-1:0];
        req       = 1'b1;
        limit     = 4 * (wid_tab[i] + 1) + 20;
        cycles    = 0;
        while (!ack && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (!ack) begin
                check_value("busy", 1, busy);
            end
        end
        if (!ack) begin
            errors++;
            $display("Timeout at %0t, no ack for edit in row %0d", $time, i);
        end else begin
            check_value("busy", 0, busy);
            check_value("error", exp_err[i], error);
            check_value("latency", exp_lat[i], cycles - 1);
            // Ack stays up while the host holds req
            repeat (2) begin
                @(negedge clk);
                check_value("ack", 1, ack);
            end
        end
        req  = 1'b0;
        hold = 0;
        while (ack && hold < 5) begin
            @(negedge clk);
            hold++;
        end
        assert (!ack) else begin
            errors++;
            $display("Ack stayed high after req dropped in row %0d", i);
        end
        check_value("error", 0, error);
    endtask

    initial begin
        reset     = 1'b1;
        req       = 1'b0;
        addr      = '0;
        op        = OP_INC;
        set_value = '0;
        cfg_we    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_wdata = '0;
        tick      = 1'b0;
        errors    = 0;
        rows      = 0;
        m_sec        = 0;
        m_min        = 0;
        m_hour       = 0;
        m_alarm_hour = 0;
        m_enable     = 1;
        m_width      = STROBE_RESET;
        rng          = 32'd59;
        build_table();

        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("ack", 0, ack);
        check_value("error", 0, error);
        check_value("busy", 0, busy);
        check_value("alarm", 0, alarm);
        check_value("sec", 0, sec);
        check_value("min", 0, min);
        check_value("hour", 0, hour);
        reset = 1'b0;
        @(negedge clk);

        for (int i = 0; i < rows; i++) begin
            if (kind_tab[i] == K_CFG) begin
                run_config(i);
            end else if (kind_tab[i] == K_TICK) begin
                run_ticks(i);
            end else begin
                run_edit(i);
            end
            // Alarm lags the hour by one cycle
            repeat (2) @(negedge clk);
            check_value("sec", exp_sec[i], sec);
            check_value("min", exp_min[i], min);
            check_value("hour", exp_hour[i], hour);
            check_value("alarm", exp_alm[i], alarm);
        end

        $display("Ran %0d table rows, %0d errors", rows, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
